// File: common/axis_pkt_fifo_defines.svh
`ifndef AXIS_PKT_FIFO_DEFINES_SVH
`define AXIS_PKT_FIFO_DEFINES_SVH

// payload width in bits
`define FIFO_DATA_W 32

// beats held by the storage core
// power of two and no less than 16
`define FIFO_DEPTH 32

// address bits plus one wrap bit
// log2(FIFO_DEPTH) + 1
`define FIFO_PTR_W 6

// beat pointers and packet pointers share this width
// since a packet is at least one beat, the packet count never laps the beat count

`endif

// File: common/axis_pkt_fifo_pkg.sv
`include "axis_pkt_fifo_defines.svh"

package axis_pkt_fifo_pkg;

	// one data word of the stream
	typedef logic [`FIFO_DATA_W-1:0] axis_data_t;

	// beat or packet pointer, binary or gray
	typedef logic [`FIFO_PTR_W-1:0] fifo_ptr_t;

	// unit that is stored and moved
	typedef struct packed {
		axis_data_t data;
		logic       last; // closes a packet
	} axis_beat_t;

	// binary to gray, used before every pointer crosses a clock boundary
	function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
		fifo_ptr_t gray;
		gray = bin ^ (bin >> 1);
		return gray;
	endfunction

endpackage

// File: async_fifo/async_fifo_core.sv
`timescale 1ns/1ps
`include "axis_pkt_fifo_defines.svh"

module async_fifo_core
	import axis_pkt_fifo_pkg::*;
(
	// write side
	input  logic       s_axis_aclk,
	input  logic       s_axis_aresetn,
	input  logic       s_axis_valid,
	input  axis_beat_t s_axis_beat,
	output logic       s_axis_ready,
	// read side
	input  logic       m_axis_aclk,
	input  logic       m_axis_aresetn,
	output logic       m_axis_valid,
	output axis_beat_t m_axis_beat,
	input  logic       m_axis_ready,
	input  logic       master_oen // from the packet counter
);

	localparam int addr_w = `FIFO_PTR_W - 1;

	// a full FIFO has the write pointer one lap ahead, which in gray
	// code flips the top two bits and leaves the rest equal
	localparam fifo_ptr_t full_mask = {2'b11, {(`FIFO_PTR_W - 2){1'b0}}};

	axis_beat_t mem [`FIFO_DEPTH];

	// write domain
	fifo_ptr_t wptr_bin;
	fifo_ptr_t wptr_bin_nxt;
	fifo_ptr_t wptr_gray;
	fifo_ptr_t rptr_gray_w_d1; // first sync stage
	fifo_ptr_t rptr_gray_w_d2;
	logic      wr_en;
	logic      full;

	// read domain
	fifo_ptr_t rptr_bin;
	fifo_ptr_t rptr_bin_nxt;
	fifo_ptr_t rptr_gray;
	fifo_ptr_t wptr_gray_r_d1; // first sync stage
	fifo_ptr_t wptr_gray_r_d2;
	logic      rd_en;
	logic      empty;

	assign wr_en        = s_axis_valid & s_axis_ready;
	assign wptr_bin_nxt = wptr_bin + fifo_ptr_t'(wr_en);

	// beat lands at the accepting edge
	always_ff @(posedge s_axis_aclk)
	begin
		if (wr_en)
			mem[wptr_bin[addr_w-1:0]] <= s_axis_beat;
	end

	always_ff @(posedge s_axis_aclk or negedge s_axis_aresetn)
	begin
		if (!s_axis_aresetn)
		begin
			wptr_bin  <= '0;
			wptr_gray <= '0;
		end
		else
		begin
			wptr_bin  <= wptr_bin_nxt;
			wptr_gray <= bin2gray(wptr_bin_nxt); // moves together with the binary one
		end
	end

	// read pointer into the write domain
	always_ff @(posedge s_axis_aclk or negedge s_axis_aresetn)
	begin
		if (!s_axis_aresetn)
		begin
			rptr_gray_w_d1 <= '0;
			rptr_gray_w_d2 <= '0;
		end
		else
		begin
			rptr_gray_w_d1 <= rptr_gray;
			rptr_gray_w_d2 <= rptr_gray_w_d1;
		end
	end

	assign full         = (wptr_gray == (rptr_gray_w_d2 ^ full_mask));
	assign s_axis_ready = ~full;

	// read port only opens while the packet counter allows it
	assign empty        = (rptr_gray == wptr_gray_r_d2);
	assign m_axis_valid = ~empty & master_oen;
	assign rd_en        = m_axis_valid & m_axis_ready;
	assign rptr_bin_nxt = rptr_bin + fifo_ptr_t'(rd_en);

	assign m_axis_beat = mem[rptr_bin[addr_w-1:0]]; // fall through without read latency

	always_ff @(posedge m_axis_aclk or negedge m_axis_aresetn)
	begin
		if (!m_axis_aresetn)
		begin
			rptr_bin  <= '0;
			rptr_gray <= '0;
		end
		else
		begin
			rptr_bin  <= rptr_bin_nxt;
			rptr_gray <= bin2gray(rptr_bin_nxt);
		end
	end

	// write pointer into the read domain
	always_ff @(posedge m_axis_aclk or negedge m_axis_aresetn)
	begin
		if (!m_axis_aresetn)
		begin
			wptr_gray_r_d1 <= '0;
			wptr_gray_r_d2 <= '0;
		end
		else
		begin
			wptr_gray_r_d1 <= wptr_gray;
			wptr_gray_r_d2 <= wptr_gray_r_d1;
		end
	end

endmodule

// File: hw/axis_packet_stat_async.sv
`timescale 1ns/1ps

module axis_packet_stat_async
	import axis_pkt_fifo_pkg::*;
(
	input  logic s_axis_aclk,
	input  logic s_axis_aresetn,
	input  logic m_axis_aclk,
	input  logic m_axis_aresetn,
	// write side handshake
	input  logic s_axis_last,
	input  logic s_axis_valid,
	input  logic s_axis_ready,
	// read side handshake
	input  logic m_axis_last,
	input  logic m_axis_valid,
	input  logic m_axis_ready,
	output logic master_oen // read port may present data
);

	fifo_ptr_t wptr_bin_at_w;  // packets written
	fifo_ptr_t wptr_gray_at_w;
	fifo_ptr_t wptr_gray_d1;
	fifo_ptr_t wptr_gray_d2;   // packets written, seen from the read side
	fifo_ptr_t rptr_bin_at_r;  // packets read
	fifo_ptr_t rptr_bin_nxt;
	logic      rd_last;
	logic      no_packet;
	logic      full_d1;
	logic      full_d2;
	logic      full_at_r;

	// count completed packets on the write side
	always_ff @(posedge s_axis_aclk or negedge s_axis_aresetn)
	begin
		if (!s_axis_aresetn)
			wptr_bin_at_w <= '0;
		else if (s_axis_valid & s_axis_ready & s_axis_last)
			wptr_bin_at_w <= wptr_bin_at_w + 1'b1;
	end

	// gray copy lags one write cycle
	always_ff @(posedge s_axis_aclk or negedge s_axis_aresetn)
	begin
		if (!s_axis_aresetn)
			wptr_gray_at_w <= '0;
		else
			wptr_gray_at_w <= bin2gray(wptr_bin_at_w);
	end

	// packet count and full level into the read domain
	always_ff @(posedge m_axis_aclk or negedge m_axis_aresetn)
	begin
		if (!m_axis_aresetn)
		begin
			wptr_gray_d1 <= '0;
			wptr_gray_d2 <= '0;
			full_d1      <= 1'b0;
			full_d2      <= 1'b0;
		end
		else
		begin
			wptr_gray_d1 <= wptr_gray_at_w;
			wptr_gray_d2 <= wptr_gray_d1;
			full_d1      <= ~s_axis_ready;
			full_d2      <= full_d1;
		end
	end

	assign rd_last      = m_axis_valid & m_axis_ready & m_axis_last;
	assign rptr_bin_nxt = rptr_bin_at_r + fifo_ptr_t'(rd_last);

	// compare against the count after this read, so the flag is right one cycle early
	always_ff @(posedge m_axis_aclk or negedge m_axis_aresetn)
	begin
		if (!m_axis_aresetn)
		begin
			rptr_bin_at_r <= '0;
			no_packet     <= 1'b1;
		end
		else
		begin
			rptr_bin_at_r <= rptr_bin_nxt;
			no_packet     <= (bin2gray(rptr_bin_nxt) == wptr_gray_d2);
		end
	end

	// held until a read after the synced full level drops
	always_ff @(posedge m_axis_aclk or negedge m_axis_aresetn)
	begin
		if (!m_axis_aresetn)
			full_at_r <= 1'b0;
		else if (full_at_r)
			full_at_r <= ~(m_axis_valid & m_axis_ready & ~full_d2);
		else
			full_at_r <= full_d2;
	end

	assign master_oen = ~no_packet | full_at_r;

endmodule

// File: hw/axis_pkt_fifo_top.sv
`timescale 1ns/1ps

module axis_pkt_fifo_top
	import axis_pkt_fifo_pkg::*;
(
	// write side
	input  logic       s_axis_aclk,
	input  logic       s_axis_aresetn,
	input  logic       s_axis_valid,
	input  axis_beat_t s_axis_beat,
	output logic       s_axis_ready,
	// read side
	input  logic       m_axis_aclk,
	input  logic       m_axis_aresetn,
	output logic       m_axis_valid,
	output axis_beat_t m_axis_beat,
	input  logic       m_axis_ready
);

	logic master_oen; // packet present or FIFO full

	async_fifo_core u_core (
		.s_axis_aclk    (s_axis_aclk),
		.s_axis_aresetn (s_axis_aresetn),
		.s_axis_valid   (s_axis_valid),
		.s_axis_beat    (s_axis_beat),
		.s_axis_ready   (s_axis_ready),
		.m_axis_aclk    (m_axis_aclk),
		.m_axis_aresetn (m_axis_aresetn),
		.m_axis_valid   (m_axis_valid),
		.m_axis_beat    (m_axis_beat),
		.m_axis_ready   (m_axis_ready),
		.master_oen     (master_oen)
	);

	// watches both handshakes and gates the read port
	axis_packet_stat_async u_pkt_stat (
		.s_axis_aclk    (s_axis_aclk),
		.s_axis_aresetn (s_axis_aresetn),
		.m_axis_aclk    (m_axis_aclk),
		.m_axis_aresetn (m_axis_aresetn),
		.s_axis_last    (s_axis_beat.last),
		.s_axis_valid   (s_axis_valid),
		.s_axis_ready   (s_axis_ready),
		.m_axis_last    (m_axis_beat.last),
		.m_axis_valid   (m_axis_valid),
		.m_axis_ready   (m_axis_ready),
		.master_oen     (master_oen)
	);

endmodule

// File: verification/tb_axis_pkt_fifo.sv
`timescale 1ns/1ps
`include "axis_pkt_fifo_defines.svh"

module tb_axis_pkt_fifo
	import axis_pkt_fifo_pkg::*;
();

	localparam int n_short  = 20; // packets with the sink always ready
	localparam int n_mixed  = 30; // packets with random ready and gaps
	localparam int long_len = 2 * `FIFO_DEPTH + 6;

	logic       s_axis_aclk;
	logic       s_axis_aresetn;
	logic       s_axis_valid;
	axis_beat_t s_axis_beat;
	logic       s_axis_ready;
	logic       m_axis_aclk;
	logic       m_axis_aresetn;
	logic       m_axis_valid;
	axis_beat_t m_axis_beat;
	logic       m_axis_ready;

	axis_beat_t  model_q[$]; // beats sent and not yet read
	int          pkt_len[$];
	logic [31:0] wr_lcg = 32'h8f895703;
	logic [31:0] rd_lcg = 32'h8f895703; // own stream for the read clock
	int          err_data = 0;
	int          err_flag = 0;
	int          err_other = 0;
	int          total_beats = 0;
	int          timeout_limit = 2000;
	int          cycle_cnt = 0;
	logic        rd_random = 1'b0;
	logic        hold_pending = 1'b0; // valid seen without a transfer
	logic        saw_full = 1'b0;

	axis_pkt_fifo_top DUT (
		.s_axis_aclk    (s_axis_aclk),
		.s_axis_aresetn (s_axis_aresetn),
		.s_axis_valid   (s_axis_valid),
		.s_axis_beat    (s_axis_beat),
		.s_axis_ready   (s_axis_ready),
		.m_axis_aclk    (m_axis_aclk),
		.m_axis_aresetn (m_axis_aresetn),
		.m_axis_valid   (m_axis_valid),
		.m_axis_beat    (m_axis_beat),
		.m_axis_ready   (m_axis_ready)
	);

	initial
	begin
		m_axis_aclk = 1'b0;
		forever #50 m_axis_aclk = ~m_axis_aclk;
	end

	initial
	begin
		s_axis_aclk = 1'b0;
		forever #35 s_axis_aclk = ~s_axis_aclk;
	end

	function automatic logic [31:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	// low bits repeat quickly so the upper ones are taken
	function automatic int rand_below(inout logic [31:0] state, input int n);
		logic [31:0] r;
		r = lcg_next(state);
		return int'(r[30:16]) % n;
	endfunction

	// expected beat of a packet
	function automatic axis_beat_t ref_pkt(input int pkt_idx, input int beat_idx, input int len);
		axis_beat_t b;
		b.data = axis_data_t'({pkt_idx[15:0], beat_idx[15:0]}) ^ 32'h3c5a96e1;
		b.last = (beat_idx == len - 1);
		return b;
	endfunction

	task automatic chk_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
		if (act !== exp)
		begin
			err_data++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic chk_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			err_flag++;
			$display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic report_counts();
		$display("errors: data %0d, flag %0d, other %0d", err_data, err_flag, err_other);
	endtask

	// each call starts and ends on a write falling edge so beats go back to back
	task automatic send_beat(input axis_beat_t b);
		s_axis_valid = 1'b1;
		s_axis_beat  = b;
		while (!s_axis_ready)
		begin
			saw_full = 1'b1;
			@(negedge s_axis_aclk);
		end
		model_q.push_back(b);
		@(negedge s_axis_aclk); // accepted at the edge in between
		s_axis_valid = 1'b0;
	endtask

	task automatic send_packet(input int pkt_idx, input int gap_max);
		int len;
		int gap;
		len = pkt_len[pkt_idx];
		for (int i = 0; i < len; i++)
		begin
			send_beat(ref_pkt(pkt_idx, i, len));
			gap = (gap_max > 0) ? rand_below(wr_lcg, gap_max + 1) : 0;
			repeat (gap) @(negedge s_axis_aclk);
		end
	endtask

	task automatic wait_drain();
		while (model_q.size() != 0)
			@(posedge s_axis_aclk);
	endtask

	// sink samples first and then drives the next ready
	always @(negedge m_axis_aclk)
	begin
		if (m_axis_aresetn)
		begin
			if (hold_pending)
				chk_flag("m_axis_valid", 1'b1, m_axis_valid); // dropped without a transfer
			m_axis_ready = rd_random ? (rand_below(rd_lcg, 4) != 0) : 1'b1;
			if (m_axis_valid && m_axis_ready)
			begin
				if (model_q.size() == 0)
				begin
					err_other++;
					$display("beat offered at %0t while nothing was left to receive", $time);
				end
				else
					chk_beat("m_axis_beat", model_q.pop_front(), m_axis_beat);
			end
			hold_pending = m_axis_valid && !m_axis_ready;
		end
	end

	always @(posedge m_axis_aclk)
	begin
		cycle_cnt++;
		if (cycle_cnt > timeout_limit)
		begin
			$display("timeout after %0d read cycles, data stopped moving", cycle_cnt);
			report_counts();
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		int idx;
		s_axis_aresetn = 1'b0;
		m_axis_aresetn = 1'b0;
		s_axis_valid   = 1'b0;
		s_axis_beat    = '0;
		m_axis_ready   = 1'b0;

		// one open packet, short ones, mixed ones, one longer than the FIFO
		pkt_len.push_back(5);
		repeat (n_short) pkt_len.push_back(1 + rand_below(wr_lcg, 8));
		repeat (n_mixed) pkt_len.push_back(1 + rand_below(wr_lcg, 12));
		pkt_len.push_back(long_len);
		foreach (pkt_len[i])
			total_beats += pkt_len[i];
		timeout_limit = total_beats * 20 + 2000;

		fork
			begin
				repeat (5) @(posedge s_axis_aclk);
				@(negedge s_axis_aclk);
				s_axis_aresetn = 1'b1;
			end
			begin
				repeat (5) @(posedge m_axis_aclk);
				@(negedge m_axis_aclk);
				m_axis_aresetn = 1'b1;
			end
		join

		@(negedge m_axis_aclk);
		chk_flag("m_axis_valid", 1'b0, m_axis_valid);
		@(negedge s_axis_aclk);
		chk_flag("s_axis_ready", 1'b1, s_axis_ready);

		// packet without its last beat stays hidden
		for (int i = 0; i < 4; i++)
			send_beat(ref_pkt(0, i, 5));
		repeat (30)
		begin
			@(negedge m_axis_aclk);
			chk_flag("m_axis_valid", 1'b0, m_axis_valid);
		end
		@(negedge s_axis_aclk);
		send_beat(ref_pkt(0, 4, 5));
		idx = 0;
		while (!m_axis_valid && idx < 50)
		begin
			@(negedge m_axis_aclk);
			idx++;
		end
		if (!m_axis_valid)
		begin
			err_other++;
			$display("m_axis_valid did not rise after the packet was closed");
		end
		wait_drain();

		@(negedge s_axis_aclk);
		for (idx = 1; idx <= n_short; idx++)
			send_packet(idx, 0);
		wait_drain();

		rd_random = 1'b1;
		@(negedge s_axis_aclk);
		for (idx = n_short + 1; idx <= n_short + n_mixed; idx++)
			send_packet(idx, 3);
		wait_drain();

		// long packet only gets out through the full rule
		saw_full = 1'b0;
		@(negedge s_axis_aclk);
		send_packet(n_short + n_mixed + 1, 0);
		wait_drain();
		chk_flag("s_axis_ready low seen", 1'b1, saw_full);

		repeat (5) @(negedge m_axis_aclk);
		chk_flag("m_axis_valid", 1'b0, m_axis_valid);

		report_counts();
		if (err_data + err_flag + err_other == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: build.f
+incdir+common
common/axis_pkt_fifo_pkg.sv
async_fifo/async_fifo_core.sv
hw/axis_packet_stat_async.sv
hw/axis_pkt_fifo_top.sv
verification/tb_axis_pkt_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	-f build.f \
	--top-module tb_axis_pkt_fifo \
	-Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
